//--- hw/image_geom_pkg.sv
package image_geom_pkg;

  // greyscale sample
  localparam int PIXEL_W = 8;
  typedef logic [PIXEL_W-1:0] pixel_t;

  // image geometry
  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 8;

  // vertical strips walked one after another
  localparam int STRIP_PIXELS = 4;
  localparam int NUM_STRIPS = IMG_COLS / STRIP_PIXELS;

  // one image-memory word is a whole row, pixel 0 in the low byte
  localparam int ROW_W = IMG_COLS * PIXEL_W;

  // one blur-memory word is one strip of one row
  localparam int STRIP_W = STRIP_PIXELS * PIXEL_W;

  typedef logic [2:0] row_idx_t;
  typedef logic [1:0] strip_idx_t;

  // row * NUM_STRIPS + strip
  typedef logic [4:0] blur_addr_t;

  // sequencer FSM
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    DRAIN
  } seq_state_t;

endpackage

//--- hw/filter_pkg.sv
package filter_pkg;

  localparam int NUM_FILTERS = 2;

  // largest radius sets the window and the padding
  localparam int MAX_RADIUS = 2;
  localparam int KERNEL_TAPS = 2 * MAX_RADIUS + 1;
  localparam int WINDOW_ROWS = KERNEL_TAPS;
  localparam int WINDOW_COLS = image_geom_pkg::STRIP_PIXELS + 2 * MAX_RADIUS;

  // 1-D binomial taps, centred in a KERNEL_TAPS wide slot
  localparam int TAP_W = 3;
  typedef logic [TAP_W-1:0] tap_t;

  localparam int FILTER_RADIUS [NUM_FILTERS] = '{1, 2};
  localparam tap_t FILTER_TAPS [NUM_FILTERS][KERNEL_TAPS] = '{
    '{3'd0, 3'd1, 3'd2, 3'd1, 3'd0},
    '{3'd1, 3'd4, 3'd6, 3'd4, 3'd1}
  };

  // log2 of the 2-D tap sum (16 and 256)
  localparam int FILTER_SHIFT [NUM_FILTERS] = '{4, 8};

  // 255 * 16 after the vertical pass, 255 * 256 after the horizontal one
  localparam int COL_SUM_W = 12;
  localparam int ACC_SUM_W = 16;
  typedef logic [COL_SUM_W-1:0] col_sum_t;
  typedef logic [ACC_SUM_W-1:0] acc_t;

  localparam int LANE_LATENCY = 2;
  localparam int DRAIN_CYCLES = 5;

  // tap lies inside the kernel's own 2*radius+1 span
  function automatic bit tap_in_use(int filt, int tap);
    return (tap >= MAX_RADIUS - FILTER_RADIUS[filt]) &&
           (tap <= MAX_RADIUS + FILTER_RADIUS[filt]);
  endfunction

endpackage

//--- hw/blur_sequencer.sv
`timescale 1ns/1ps

module blur_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  output image_geom_pkg::row_idx_t   img_addr,
  output logic                       fetch,
  output logic                       fill_zero,
  output logic                       center_valid,
  output image_geom_pkg::row_idx_t   center_row,
  output image_geom_pkg::strip_idx_t strip,
  output logic                       done
);

  image_geom_pkg::seq_state_t state;
  // 0..7 real rows, 8..9 padding rows
  logic [3:0]                 fetch_idx;
  image_geom_pkg::strip_idx_t strip_cnt;
  logic [2:0]                 drain_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= image_geom_pkg::IDLE;
      fetch_idx <= '0;
      strip_cnt <= '0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      case (state)
        image_geom_pkg::IDLE: begin
          if (start) begin
            state     <= image_geom_pkg::FETCH;
            fetch_idx <= '0;
            strip_cnt <= '0;
            done      <= 1'b0;
          end
        end
        image_geom_pkg::FETCH: begin
          if (fetch_idx == image_geom_pkg::IMG_ROWS + filter_pkg::MAX_RADIUS - 1) begin
            fetch_idx <= '0;
            if (strip_cnt == image_geom_pkg::NUM_STRIPS - 1) begin
              state     <= image_geom_pkg::DRAIN;
              drain_cnt <= '0;
            end else begin
              strip_cnt <= strip_cnt + 1'b1;
            end
          end else begin
            fetch_idx <= fetch_idx + 1'b1;
          end
        end
        image_geom_pkg::DRAIN: begin
          // let the last rows clear memory, window, lanes and writer
          if (drain_cnt == filter_pkg::DRAIN_CYCLES - 1) begin
            state <= image_geom_pkg::IDLE;
            done  <= 1'b1;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        default: state <= image_geom_pkg::IDLE;
      endcase
    end
  end

  assign fetch     = (state == image_geom_pkg::FETCH);
  assign fill_zero = fetch && (fetch_idx >= image_geom_pkg::IMG_ROWS);

  // padding fetches wrap onto rows 0/1, their data is dropped by the feeder
  assign img_addr = image_geom_pkg::row_idx_t'(fetch_idx);

  // window is centred MAX_RADIUS rows behind the newest fetch
  assign center_valid = fetch && (fetch_idx >= filter_pkg::MAX_RADIUS);
  assign center_row   = image_geom_pkg::row_idx_t'(fetch_idx - filter_pkg::MAX_RADIUS);
  assign strip        = strip_cnt;

endmodule

//--- hw/window_feeder.sv
`timescale 1ns/1ps

module window_feeder (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              fetch,
  input  logic                              fill_zero,
  input  logic                              center_valid,
  input  image_geom_pkg::row_idx_t          center_row,
  input  image_geom_pkg::strip_idx_t        strip,
  input  logic [image_geom_pkg::ROW_W-1:0]  img_dout,
  output image_geom_pkg::pixel_t [filter_pkg::WINDOW_ROWS-1:0][filter_pkg::WINDOW_COLS-1:0]
                                            window,
  output logic                              window_valid,
  output image_geom_pkg::row_idx_t          window_row,
  output image_geom_pkg::strip_idx_t        window_strip
);

  // fetch tags, delayed to line up with the memory answer
  logic                       fetch_d;
  logic                       fill_zero_d;
  logic                       center_valid_d;
  image_geom_pkg::row_idx_t   center_row_d;
  image_geom_pkg::strip_idx_t strip_d;

  image_geom_pkg::pixel_t [filter_pkg::WINDOW_COLS-1:0] new_row;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_d        <= 1'b0;
      fill_zero_d    <= 1'b0;
      center_valid_d <= 1'b0;
    end else begin
      fetch_d        <= fetch;
      fill_zero_d    <= fill_zero;
      center_valid_d <= center_valid;
    end
  end

  always_ff @(posedge clk) begin
    center_row_d <= center_row;
    strip_d      <= strip;
  end

  // strip plus halo out of the landed row, zero outside the image
  always_comb begin
    int col;
    for (int c = 0; c < filter_pkg::WINDOW_COLS; c++) begin
      col = int'(strip_d) * image_geom_pkg::STRIP_PIXELS + c - filter_pkg::MAX_RADIUS;
      if (fill_zero_d || col < 0 || col >= image_geom_pkg::IMG_COLS) begin
        new_row[c] = '0;
      end else begin
        new_row[c] = img_dout[col*image_geom_pkg::PIXEL_W +: image_geom_pkg::PIXEL_W];
      end
    end
  end

  // newest row enters at the top index
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      window       <= '0;
      window_valid <= 1'b0;
    end else begin
      window_valid <= fetch_d && center_valid_d;
      if (fetch_d) begin
        for (int r = 0; r < filter_pkg::WINDOW_ROWS - 1; r++) begin
          window[r] <= window[r+1];
        end
        window[filter_pkg::WINDOW_ROWS-1] <= new_row;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_d) begin
      window_row   <= center_row_d;
      window_strip <= strip_d;
    end
  end

endmodule

//--- hw/blur_lane.sv
`timescale 1ns/1ps

module blur_lane #(
  parameter int FILTER_IDX = 0
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  image_geom_pkg::pixel_t [filter_pkg::WINDOW_ROWS-1:0][filter_pkg::WINDOW_COLS-1:0]
                                              window,
  output logic [image_geom_pkg::STRIP_W-1:0]  result
);

  filter_pkg::col_sum_t [filter_pkg::WINDOW_COLS-1:0] col_sum;
  filter_pkg::col_sum_t [filter_pkg::WINDOW_COLS-1:0] col_sum_q;
  image_geom_pkg::pixel_t [image_geom_pkg::STRIP_PIXELS-1:0] blurred;

  // stage 1, vertical taps per window column
  always_comb begin
    for (int c = 0; c < filter_pkg::WINDOW_COLS; c++) begin
      col_sum[c] = '0;
      for (int t = 0; t < filter_pkg::KERNEL_TAPS; t++) begin
        if (filter_pkg::tap_in_use(FILTER_IDX, t)) begin
          col_sum[c] = col_sum[c] +
                       filter_pkg::col_sum_t'(filter_pkg::FILTER_TAPS[FILTER_IDX][t]) *
                       filter_pkg::col_sum_t'(window[t][c]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_sum_q <= '0;
    end else begin
      col_sum_q <= col_sum;
    end
  end

  // stage 2, horizontal taps around each strip pixel
  always_comb begin
    filter_pkg::acc_t acc;
    for (int p = 0; p < image_geom_pkg::STRIP_PIXELS; p++) begin
      acc = '0;
      // strip pixel p sits at window column p + MAX_RADIUS
      for (int u = 0; u < filter_pkg::KERNEL_TAPS; u++) begin
        if (filter_pkg::tap_in_use(FILTER_IDX, u)) begin
          acc = acc +
                filter_pkg::acc_t'(filter_pkg::FILTER_TAPS[FILTER_IDX][u]) *
                filter_pkg::acc_t'(col_sum_q[p+u]);
        end
      end
      // normalise, keep the low byte
      blurred[p] = image_geom_pkg::pixel_t'(acc >> filter_pkg::FILTER_SHIFT[FILTER_IDX]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
    end else begin
      result <= blurred;
    end
  end

endmodule

//--- hw/result_writer.sv
`timescale 1ns/1ps

module result_writer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              window_valid,
  input  image_geom_pkg::row_idx_t          window_row,
  input  image_geom_pkg::strip_idx_t        window_strip,
  input  logic [filter_pkg::NUM_FILTERS-1:0][image_geom_pkg::STRIP_W-1:0] result,
  output logic [filter_pkg::NUM_FILTERS-1:0] blur_we,
  output image_geom_pkg::blur_addr_t        blur_addr,
  output logic [filter_pkg::NUM_FILTERS-1:0][image_geom_pkg::STRIP_W-1:0] blur_din
);

  // tags ride alongside the lane pipeline
  logic [filter_pkg::LANE_LATENCY-1:0] valid_pipe;
  image_geom_pkg::row_idx_t            row_pipe   [filter_pkg::LANE_LATENCY];
  image_geom_pkg::strip_idx_t          strip_pipe [filter_pkg::LANE_LATENCY];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_pipe <= '0;
      blur_we    <= '0;
    end else begin
      valid_pipe[0] <= window_valid;
      for (int i = 1; i < filter_pkg::LANE_LATENCY; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
      // every kernel writes in the same cycle
      blur_we <= {filter_pkg::NUM_FILTERS{valid_pipe[filter_pkg::LANE_LATENCY-1]}};
    end
  end

  always_ff @(posedge clk) begin
    row_pipe[0]   <= window_row;
    strip_pipe[0] <= window_strip;
    for (int i = 1; i < filter_pkg::LANE_LATENCY; i++) begin
      row_pipe[i]   <= row_pipe[i-1];
      strip_pipe[i] <= strip_pipe[i-1];
    end
    blur_addr <= image_geom_pkg::blur_addr_t'(
                   row_pipe[filter_pkg::LANE_LATENCY-1] * image_geom_pkg::NUM_STRIPS +
                   strip_pipe[filter_pkg::LANE_LATENCY-1]);
    blur_din  <= result;
  end

endmodule

//--- hw/gaussian_blur_top.sv
`timescale 1ns/1ps

module gaussian_blur_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start,
  input  logic [image_geom_pkg::ROW_W-1:0]  img_dout,
  output image_geom_pkg::row_idx_t          img_addr,
  output logic                              done,
  output logic [filter_pkg::NUM_FILTERS-1:0] blur_we,
  output image_geom_pkg::blur_addr_t        blur_addr,
  output logic [filter_pkg::NUM_FILTERS-1:0][image_geom_pkg::STRIP_W-1:0] blur_din
);

  // sequencer to feeder
  logic                       fetch;
  logic                       fill_zero;
  logic                       center_valid;
  image_geom_pkg::row_idx_t   center_row;
  image_geom_pkg::strip_idx_t strip;

  // feeder to lanes and writer
  image_geom_pkg::pixel_t [filter_pkg::WINDOW_ROWS-1:0][filter_pkg::WINDOW_COLS-1:0] window;
  logic                       window_valid;
  image_geom_pkg::row_idx_t   window_row;
  image_geom_pkg::strip_idx_t window_strip;

  logic [filter_pkg::NUM_FILTERS-1:0][image_geom_pkg::STRIP_W-1:0] lane_result;

  blur_sequencer sequencer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .img_addr     (img_addr),
    .fetch        (fetch),
    .fill_zero    (fill_zero),
    .center_valid (center_valid),
    .center_row   (center_row),
    .strip        (strip),
    .done         (done)
  );

  window_feeder feeder_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch        (fetch),
    .fill_zero    (fill_zero),
    .center_valid (center_valid),
    .center_row   (center_row),
    .strip        (strip),
    .img_dout     (img_dout),
    .window       (window),
    .window_valid (window_valid),
    .window_row   (window_row),
    .window_strip (window_strip)
  );

  // one lane per kernel, all fed from the same window
  for (genvar i = 0; i < filter_pkg::NUM_FILTERS; i++) begin : gen_lane
    blur_lane #(
      .FILTER_IDX (i)
    ) lane_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .window (window),
      .result (lane_result[i])
    );
  end

  result_writer writer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .window_valid (window_valid),
    .window_row   (window_row),
    .window_strip (window_strip),
    .result       (lane_result),
    .blur_we      (blur_we),
    .blur_addr    (blur_addr),
    .blur_din     (blur_din)
  );

endmodule

//--- bench/tb_blur_model.sv
`timescale 1ns/1ps

module tb_blur_model (
  input  logic                               clk,
  input  image_geom_pkg::row_idx_t           img_addr,
  output logic [image_geom_pkg::ROW_W-1:0]   img_dout,
  input  logic [filter_pkg::NUM_FILTERS-1:0] blur_we,
  input  image_geom_pkg::blur_addr_t         blur_addr,
  input  logic [filter_pkg::NUM_FILTERS-1:0][image_geom_pkg::STRIP_W-1:0] blur_din
);

  localparam int ROWS = image_geom_pkg::IMG_ROWS;
  localparam int COLS = image_geom_pkg::IMG_COLS;
  localparam int PW = image_geom_pkg::PIXEL_W;
  localparam int NUM_WORDS = ROWS * image_geom_pkg::NUM_STRIPS;

  image_geom_pkg::pixel_t image [ROWS][COLS];
  logic [image_geom_pkg::ROW_W-1:0] row_q = '0;
  logic [15:0] lfsr_state = 16'd33705;

  // blur-memory traffic seen during one run
  logic [image_geom_pkg::STRIP_W-1:0] captured [filter_pkg::NUM_FILTERS][NUM_WORDS];
  int write_count [NUM_WORDS];

  // synchronous read, one cycle latency
  always @(posedge clk) begin
    for (int c = 0; c < COLS; c++) begin
      row_q[c*PW +: PW] <= image[img_addr][c];
    end
  end

  assign img_dout = row_q;

  always @(negedge clk) begin
    if (blur_we != '0) begin
      write_count[blur_addr] = write_count[blur_addr] + 1;
      for (int k = 0; k < filter_pkg::NUM_FILTERS; k++) begin
        if (blur_we[k]) begin
          captured[k][blur_addr] = blur_din[k];
        end
      end
    end
  end

  task automatic clear_capture();
    for (int a = 0; a < NUM_WORDS; a++) begin
      write_count[a] = 0;
      for (int k = 0; k < filter_pkg::NUM_FILTERS; k++) begin
        captured[k][a] = '0;
      end
    end
  endtask

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic image_geom_pkg::pixel_t random_pixel();
    image_geom_pkg::pixel_t p;
    for (int b = 0; b < PW; b++) begin
      p[b] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return p;
  endfunction

  task automatic load_image(input string pattern, input int value);
    image_geom_pkg::pixel_t pix;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        if (pattern == "flat") begin
          pix = image_geom_pkg::pixel_t'(value);
        end else if (pattern == "impulse") begin
          // first column of strip 1, strip 0 sees it only through its halo
          pix = (r == 3 && c == 4) ? image_geom_pkg::pixel_t'(value) : '0;
        end else if (pattern == "ramp") begin
          pix = image_geom_pkg::pixel_t'(value + r * COLS + c);
        end else begin
          pix = random_pixel();
        end
        image[r][c] = pix;
      end
    end
  endtask

  function automatic int binomial(int n, int k);
    int v;
    v = 1;
    for (int i = 0; i < k; i++) begin
      v = v * (n - i) / (i + 1);
    end
    return v;
  endfunction

  // zero-padded 2-D binomial blur of one pixel
  function automatic image_geom_pkg::pixel_t ref_pixel(int filt, int row, int col);
    int rad;
    int acc;
    int r;
    int c;
    rad = filter_pkg::FILTER_RADIUS[filt];
    acc = 0;
    for (int dy = -rad; dy <= rad; dy++) begin
      for (int dx = -rad; dx <= rad; dx++) begin
        r = row + dy;
        c = col + dx;
        if (r >= 0 && r < ROWS && c >= 0 && c < COLS) begin
          acc += binomial(2 * rad, dy + rad) * binomial(2 * rad, dx + rad) * int'(image[r][c]);
        end
      end
    end
    // each 1-D row of taps sums to 2**(2*rad)
    return image_geom_pkg::pixel_t'(acc >> (4 * rad));
  endfunction

  function automatic logic [image_geom_pkg::STRIP_W-1:0] ref_word(int filt, int row, int strip);
    logic [image_geom_pkg::STRIP_W-1:0] word;
    for (int p = 0; p < image_geom_pkg::STRIP_PIXELS; p++) begin
      word[p*PW +: PW] = ref_pixel(filt, row, strip * image_geom_pkg::STRIP_PIXELS + p);
    end
    return word;
  endfunction

endmodule

//--- bench/tb_gaussian_blur.sv
`timescale 1ns/1ps

module tb_gaussian_blur;

  localparam int NUM_TESTS = 6;
  localparam int RESET_CYCLES = 10;
  localparam int RUN_CYCLES = image_geom_pkg::NUM_STRIPS *
    (image_geom_pkg::IMG_ROWS + filter_pkg::MAX_RADIUS) + filter_pkg::DRAIN_CYCLES + 20;
  localparam int CYCLE_LIMIT = NUM_TESTS * RUN_CYCLES + RESET_CYCLES;
  localparam int NUM_WORDS = image_geom_pkg::IMG_ROWS * image_geom_pkg::NUM_STRIPS;
  localparam int PW = image_geom_pkg::PIXEL_W;

  logic                               clk = 1'b0;
  logic                               rst_n;
  logic                               start;
  logic [image_geom_pkg::ROW_W-1:0]   img_dout;
  image_geom_pkg::row_idx_t           img_addr;
  logic                               done;
  logic [filter_pkg::NUM_FILTERS-1:0] blur_we;
  image_geom_pkg::blur_addr_t         blur_addr;
  logic [filter_pkg::NUM_FILTERS-1:0][image_geom_pkg::STRIP_W-1:0] blur_din;

  // test table, interior of -1 means no flat-field expectation
  string test_name [NUM_TESTS];
  string test_pattern [NUM_TESTS];
  int    test_value [NUM_TESTS];
  int    test_interior [NUM_TESTS];

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  gaussian_blur_top gaussian_blur_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .img_dout  (img_dout),
    .img_addr  (img_addr),
    .done      (done),
    .blur_we   (blur_we),
    .blur_addr (blur_addr),
    .blur_din  (blur_din)
  );

  tb_blur_model model_inst (
    .clk       (clk),
    .img_addr  (img_addr),
    .img_dout  (img_dout),
    .blur_we   (blur_we),
    .blur_addr (blur_addr),
    .blur_din  (blur_din)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic compare_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] got);
    check_count++;
    assert (got == exp) else begin
      $display("FAILED %s %s: expected %h, actual %h", test, what, exp, got);
      error_count++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    check_count++;
    assert (cond) else begin
      $display("error: %s", msg);
      error_count++;
    end
  endtask

  // flat image gives v inside, less than v where the kernel hangs over the edge
  task automatic check_flat_strip(input int t, input int f, input int r, input int s,
                                  input logic [image_geom_pkg::STRIP_W-1:0] word);
    int rad;
    int col;
    image_geom_pkg::pixel_t pix;
    rad = filter_pkg::FILTER_RADIUS[f];
    for (int p = 0; p < image_geom_pkg::STRIP_PIXELS; p++) begin
      col = s * image_geom_pkg::STRIP_PIXELS + p;
      pix = word[p*PW +: PW];
      if (r >= rad && r < image_geom_pkg::IMG_ROWS - rad &&
          col >= rad && col < image_geom_pkg::IMG_COLS - rad) begin
        compare_value(test_name[t], $sformatf("kernel %0d interior (%0d,%0d)", f, r, col),
                      test_interior[t], pix);
      end else begin
        check_true(int'(pix) < test_value[t],
                   $sformatf("%s kernel %0d border pixel (%0d,%0d) not below flat value",
                             test_name[t], f, r, col));
      end
    end
  endtask

  task automatic compare_results(input int t);
    logic [image_geom_pkg::STRIP_W-1:0] got_word;
    int addr;
    for (int f = 0; f < filter_pkg::NUM_FILTERS; f++) begin
      for (int r = 0; r < image_geom_pkg::IMG_ROWS; r++) begin
        for (int s = 0; s < image_geom_pkg::NUM_STRIPS; s++) begin
          addr = r * image_geom_pkg::NUM_STRIPS + s;
          got_word = model_inst.captured[f][addr];
          compare_value(test_name[t], $sformatf("kernel %0d addr %0d", f, addr),
                        model_inst.ref_word(f, r, s), got_word);
          if (test_interior[t] >= 0) begin
            check_flat_strip(t, f, r, s, got_word);
          end
        end
      end
    end
    for (int a = 0; a < NUM_WORDS; a++) begin
      check_true(model_inst.write_count[a] == 1,
                 $sformatf("%s: address %0d written %0d times instead of once",
                           test_name[t], a, model_inst.write_count[a]));
    end
  endtask

  task automatic run_test(input int t);
    model_inst.load_image(test_pattern[t], test_value[t]);
    model_inst.clear_capture();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_true(done == 1'b0, "done still high the cycle after start");
    while (!done) begin
      @(negedge clk);
      check_true(blur_we == '0 || blur_we == '1, "blur_we bits of the kernels differ");
    end
    compare_results(t);
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    test_name     = '{"flat_200", "impulse", "ramp", "random_a", "random_b", "flat_1"};
    test_pattern  = '{"flat", "impulse", "ramp", "random", "random", "flat"};
    test_value    = '{200, 255, 100, 0, 0, 1};
    test_interior = '{200, -1, -1, -1, -1, 1};
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    // quiet outputs before the first start
    repeat (4) begin
      @(negedge clk);
      check_true(blur_we == '0 && done == 1'b0, "blur_we or done active before any start");
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
hw/image_geom_pkg.sv
hw/filter_pkg.sv
hw/blur_sequencer.sv
hw/window_feeder.sv
hw/blur_lane.sv
hw/result_writer.sv
hw/gaussian_blur_top.sv
bench/tb_blur_model.sv
bench/tb_gaussian_blur.sv

//--- run_sim.sh
#!/bin/sh
# build the blur engine testbench with Verilator, run it, judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_gaussian_blur \
  -f flist.f -o tb_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_sim | tee sim.log
grep -qx "Simulation finished: PASS" sim.log && echo "run passed" && exit 0 || exit 1
